/* hw/mmsSmdPkg.sv */
//====================================================================
// Octet codes of Table 99-1. Each packed array is indexed by its count.
//====================================================================
package mmsSmdPkg;

    // Preamble octet, repeated any number of times before the SMD.
    localparam logic [7:0] preambleOctet = 8'h55;

    // Single-code delimiters.
    localparam logic [7:0] smdExpress = 8'hD5;
    localparam logic [7:0] smdVerify  = 8'h07;
    localparam logic [7:0] smdRespond = 8'h19;

    // SMD-S by frame count 0 to 3.
    localparam logic [3:0][7:0] smdStartCodes = {8'hB3, 8'h7F, 8'h4C, 8'hE6};

    // SMD-C by frame count 0 to 3.
    localparam logic [3:0][7:0] smdContCodes = {8'h2A, 8'h9E, 8'h52, 8'h61};

    // Fragment count octet that follows an SMD-C.
    // Same values as SMD-S, but a separate field on the wire.
    localparam logic [3:0][7:0] fragCountCodes = {8'hB3, 8'h7F, 8'h4C, 8'hE6};

endpackage

/* hw/mmsRxPkg.sv */
//====================================================================
// CRC is the reflected CRC-32; an mCRC is the FCS value XOR mcrcMask.
//====================================================================
package mmsRxPkg;

    // Kind of mPacket found by the SMD decoder.
    typedef enum logic [2:0]
    {
        kindExpress,
        kindStart,
        kindCont,
        kindVerify,
        kindRespond,
        kindBad
    } mPacketKind;

    // Output stream an mPacket is steered to.
    typedef enum logic [1:0]
    {
        portExpress,
        portPreempt,
        portVerify
    } deliverPort;

    // Frame count and fragment count share this width.
    typedef logic [1:0] frameCount;

    localparam logic [31:0] crcPoly  = 32'hEDB88320;
    localparam logic [31:0] crcInit  = 32'hFFFFFFFF;
    localparam logic [31:0] mcrcMask = 32'h0000FFFF;

    // Advance the running CRC by one octet, LSB first.
    function automatic logic [31:0] crcNextOctet(input logic [31:0] crc,
                                                 input logic [7:0]  octet);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++)
        begin
            if (c[0] ^ octet[i])
                c = (c >> 1) ^ crcPoly;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

/* hw/smdDecode.sv */
`timescale 1ns/1ps
//====================================================================
// An mPacket is one run of rxDv; preamble length is not checked.
// Unknown SMD or fragment count codes give kindBad and no data octets.
//====================================================================
module smdDecode
    import mmsSmdPkg::*, mmsRxPkg::*;
(
    input  logic       clk,
    input  logic       reset_begin,
    input  logic       rxDv,
    input  logic [7:0] rxData,
    output logic       octValid,
    output logic [7:0] octData,
    output logic       pktStart,
    output mPacketKind pktKind,
    output frameCount  pktFrame,
    output frameCount  pktFrag,
    output logic       pktEnd
);

    // Hunt covers idle and preamble; drop swallows a bad mPacket.
    typedef enum logic [1:0] {stHunt, stFrag, stData, stDrop} decodeState;

    decodeState state;
    logic       firstOct;
    mPacketKind smdKind;
    frameCount  smdFrame;
    logic       fragHit;
    frameCount  fragVal;

    // Table lookup of the current octet as SMD and as fragment count.
    always_comb
    begin
        smdKind  = kindBad;
        smdFrame = '0;
        fragHit  = 1'b0;
        fragVal  = '0;
        if (rxData == smdExpress)
            smdKind = kindExpress;
        else if (rxData == smdVerify)
            smdKind = kindVerify;
        else if (rxData == smdRespond)
            smdKind = kindRespond;
        for (int i = 0; i < 4; i++)
        begin
            if (rxData == smdStartCodes[i])
            begin
                smdKind  = kindStart;
                smdFrame = frameCount'(i);
            end
            if (rxData == smdContCodes[i])
            begin
                smdKind  = kindCont;
                smdFrame = frameCount'(i);
            end
            if (rxData == fragCountCodes[i])
            begin
                fragHit = 1'b1;
                fragVal = frameCount'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            state    <= stHunt;
            firstOct <= 1'b0;
            octValid <= 1'b0;
            pktStart <= 1'b0;
            pktEnd   <= 1'b0;
            pktKind  <= kindExpress;
            pktFrame <= '0;
            pktFrag  <= '0;
        end
        else
        begin
            // Pulses by default.
            octValid <= 1'b0;
            pktStart <= 1'b0;
            pktEnd   <= 1'b0;
            case (state)
                stHunt:
                    // First non-preamble octet is the SMD.
                    if (rxDv && rxData != preambleOctet)
                    begin
                        pktKind  <= smdKind;
                        pktFrame <= smdFrame;
                        firstOct <= 1'b1;
                        if (smdKind == kindBad)
                        begin
                            pktStart <= 1'b1;
                            state    <= stDrop;
                        end
                        else if (smdKind == kindCont)
                            state <= stFrag;
                        else
                            state <= stData;
                    end
                stFrag:
                    // Fragment count octet after SMD-C.
                    if (!rxDv)
                        state <= stHunt;
                    else if (fragHit)
                    begin
                        pktFrag <= fragVal;
                        state   <= stData;
                    end
                    else
                    begin
                        pktKind  <= kindBad;
                        pktStart <= 1'b1;
                        state    <= stDrop;
                    end
                stData:
                    if (!rxDv)
                    begin
                        // No end for an mPacket that never started.
                        pktEnd <= !firstOct;
                        state  <= stHunt;
                    end
                    else
                    begin
                        octValid <= 1'b1;
                        pktStart <= firstOct;
                        firstOct <= 1'b0;
                    end
                default:
                    if (!rxDv)
                    begin
                        pktEnd <= 1'b1;
                        state  <= stHunt;
                    end
            endcase
        end
    end

    // Data path, follows rxData one cycle late.
    always_ff @(posedge clk)
    begin
        octData <= rxData;
    end

endmodule

/* hw/fragmentSequencer.sv */
`timescale 1ns/1ps
//====================================================================
// contOk must reflect the last preemptable fragment before the next SMD.
// kindBad mPackets are dropped and leave an open packet untouched.
//====================================================================
module fragmentSequencer
    import mmsRxPkg::*;
(
    input  logic       clk,
    input  logic       reset_begin,
    input  logic       octValid,
    input  logic [7:0] octData,
    input  logic       pktStart,
    input  mPacketKind pktKind,
    input  frameCount  pktFrame,
    input  frameCount  pktFrag,
    input  logic       pktEnd,
    input  logic       contOk,
    output logic       fwdValid,
    output logic [7:0] fwdData,
    output deliverPort fwdPort,
    output logic       fwdStart,
    output logic       fwdEnd,
    output mPacketKind fwdKind,
    output logic       fwdAbort
);

    // Open preempted packet.
    frameCount  openFrame;
    frameCount  nextFrag;
    // Current mPacket is being forwarded.
    logic       curFwd;
    logic       contMatch;
    logic       startFwd;
    deliverPort startPort;

    // Routing decision for an mPacket at its first octet.
    always_comb
    begin
        // contOk high means a packet is open and waits for SMD-C.
        contMatch = contOk && pktFrame == openFrame && pktFrag == nextFrag;
        startFwd  = 1'b1;
        startPort = portExpress;
        case (pktKind)
            kindExpress:
                startPort = portExpress;
            kindStart:
                startPort = portPreempt;
            kindCont:
            begin
                startPort = portPreempt;
                startFwd  = contMatch;
            end
            kindVerify, kindRespond:
                startPort = portVerify;
            default:
                startFwd = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            curFwd    <= 1'b0;
            fwdValid  <= 1'b0;
            fwdStart  <= 1'b0;
            fwdEnd    <= 1'b0;
            fwdAbort  <= 1'b0;
            fwdPort   <= portExpress;
            fwdKind   <= kindExpress;
            openFrame <= '0;
            nextFrag  <= '0;
        end
        else
        begin
            fwdValid <= octValid && (pktStart ? startFwd : curFwd);
            fwdStart <= pktStart && startFwd;
            fwdEnd   <= pktEnd && curFwd;
            // New SMD-S or a rejected SMD-C kills the waiting packet.
            fwdAbort <= pktStart && contOk &&
                        (pktKind == kindStart || (pktKind == kindCont && !contMatch));
            if (pktStart)
            begin
                curFwd <= startFwd;
                if (startFwd)
                begin
                    fwdPort <= startPort;
                    fwdKind <= pktKind;
                end
                if (pktKind == kindStart)
                begin
                    openFrame <= pktFrame;
                    nextFrag  <= '0;
                end
                // Fragment count wraps modulo 4.
                if (pktKind == kindCont && contMatch)
                    nextFrag <= nextFrag + 2'd1;
            end
        end
    end

    // Octet payload.
    always_ff @(posedge clk)
    begin
        fwdData <= octData;
    end

endmodule

/* hw/packetDeliver.sv */
`timescale 1ns/1ps
//====================================================================
// Preemptable CRC runs from SMD-S across all SMD-C fragments.
// An mPacket with fewer than four octets ends as errored.
//====================================================================
module packetDeliver
    import mmsRxPkg::*;
(
    input  logic       clk,
    input  logic       reset_begin,
    input  logic       fwdValid,
    input  logic [7:0] fwdData,
    input  deliverPort fwdPort,
    input  logic       fwdStart,
    input  logic       fwdEnd,
    input  mPacketKind fwdKind,
    input  logic       fwdAbort,
    output logic       contOk,
    output logic       eValid,
    output logic [7:0] eData,
    output logic       eEnd,
    output logic       eErr,
    output logic       pValid,
    output logic [7:0] pData,
    output logic       pEnd,
    output logic       pErr,
    output logic       verifyRcvd,
    output logic       respondRcvd
);

    // Four-octet delay line, newest in [3], oldest in [0].
    logic [3:0][7:0] held;
    logic [2:0]      heldCnt;
    deliverPort      curPort;
    mPacketKind      curKind;
    // Express and verify share one CRC, they never overlap.
    logic [31:0]     crcE;
    logic [31:0]     crcP;
    logic [31:0]     crcCur;
    logic            leaving;
    logic            fullCheck;
    logic            isFcs;
    logic            isMcrc;

    always_comb
    begin
        fullCheck = heldCnt == 3'd4;
        // Oldest octet leaves once four newer ones sit behind it.
        leaving   = fwdValid && !fwdStart && fullCheck;
        crcCur    = (curPort == portPreempt) ? crcP : crcE;
        // Held octets read as a 32-bit check, low octet first.
        isFcs     = fullCheck && held == ~crcCur;
        isMcrc    = fullCheck && held == (~crcCur ^ mcrcMask);
    end

    always_ff @(posedge clk)
    begin
        if (reset_begin)
        begin
            heldCnt     <= '0;
            curPort     <= portExpress;
            curKind     <= kindExpress;
            contOk      <= 1'b0;
            eValid      <= 1'b0;
            eEnd        <= 1'b0;
            eErr        <= 1'b0;
            pValid      <= 1'b0;
            pEnd        <= 1'b0;
            pErr        <= 1'b0;
            verifyRcvd  <= 1'b0;
            respondRcvd <= 1'b0;
        end
        else
        begin
            eValid <= leaving && curPort == portExpress;
            pValid <= leaving && curPort == portPreempt;
            // Express always ends with a marker.
            eEnd   <= fwdEnd && curPort == portExpress;
            eErr   <= fwdEnd && curPort == portExpress && !isFcs;
            // Preemptable mCRC ending gives no marker.
            pEnd   <= fwdEnd && curPort == portPreempt && isFcs;
            pErr   <= fwdAbort ||
                      (fwdEnd && curPort == portPreempt && !isFcs && !isMcrc);
            verifyRcvd  <= fwdEnd && curPort == portVerify && isMcrc &&
                           curKind == kindVerify;
            respondRcvd <= fwdEnd && curPort == portVerify && isMcrc &&
                           curKind == kindRespond;
            if (fwdValid)
                heldCnt <= fwdStart ? 3'd1 : (fullCheck ? 3'd4 : heldCnt + 3'd1);
            if (fwdStart)
            begin
                curPort <= fwdPort;
                curKind <= fwdKind;
            end
            // Waiting for continuation only between fragments.
            if (fwdAbort || (fwdStart && fwdPort == portPreempt))
                contOk <= 1'b0;
            else if (fwdEnd && curPort == portPreempt && isMcrc)
                contOk <= 1'b1;
        end
    end

    // Delay line, output octets and running CRCs.
    always_ff @(posedge clk)
    begin
        if (fwdValid)
            held <= {fwdData, held[3:1]};
        if (leaving)
        begin
            eData <= held[0];
            pData <= held[0];
        end
        if (fwdStart && fwdPort != portPreempt)
            crcE <= crcInit;
        else if (leaving && curPort != portPreempt)
            crcE <= crcNextOctet(crcE, held[0]);
        // SMD-C keeps the CRC of the fragments before it.
        if (fwdStart && fwdKind == kindStart)
            crcP <= crcInit;
        else if (leaving && curPort == portPreempt)
            crcP <= crcNextOctet(crcP, held[0]);
    end

endmodule

/* hw/mergeRx.sv */
`timescale 1ns/1ps
//====================================================================
// Receive side only; no back-pressure on any output stream.
//====================================================================
module mergeRx
    import mmsRxPkg::*;
(
    input  logic       clk,
    input  logic       reset_begin,
    input  logic       rxDv,
    input  logic [7:0] rxData,
    output logic       eValid,
    output logic [7:0] eData,
    output logic       eEnd,
    output logic       eErr,
    output logic       pValid,
    output logic [7:0] pData,
    output logic       pEnd,
    output logic       pErr,
    output logic       verifyRcvd,
    output logic       respondRcvd
);

    // Decode to sequencer.
    logic       octValid;
    logic [7:0] octData;
    logic       pktStart;
    mPacketKind pktKind;
    frameCount  pktFrame;
    frameCount  pktFrag;
    logic       pktEnd;

    // Sequencer to delivery, and the mCRC feedback.
    logic       fwdValid;
    logic [7:0] fwdData;
    deliverPort fwdPort;
    logic       fwdStart;
    logic       fwdEnd;
    mPacketKind fwdKind;
    logic       fwdAbort;
    logic       contOk;

    smdDecode smdDecode_i (
        .clk         (clk),
        .reset_begin (reset_begin),
        .rxDv        (rxDv),
        .rxData      (rxData),
        .octValid    (octValid),
        .octData     (octData),
        .pktStart    (pktStart),
        .pktKind     (pktKind),
        .pktFrame    (pktFrame),
        .pktFrag     (pktFrag),
        .pktEnd      (pktEnd)
    );

    fragmentSequencer fragmentSequencer_i (
        .clk         (clk),
        .reset_begin (reset_begin),
        .octValid    (octValid),
        .octData     (octData),
        .pktStart    (pktStart),
        .pktKind     (pktKind),
        .pktFrame    (pktFrame),
        .pktFrag     (pktFrag),
        .pktEnd      (pktEnd),
        .contOk      (contOk),
        .fwdValid    (fwdValid),
        .fwdData     (fwdData),
        .fwdPort     (fwdPort),
        .fwdStart    (fwdStart),
        .fwdEnd      (fwdEnd),
        .fwdKind     (fwdKind),
        .fwdAbort    (fwdAbort)
    );

    packetDeliver packetDeliver_i (
        .clk         (clk),
        .reset_begin (reset_begin),
        .fwdValid    (fwdValid),
        .fwdData     (fwdData),
        .fwdPort     (fwdPort),
        .fwdStart    (fwdStart),
        .fwdEnd      (fwdEnd),
        .fwdKind     (fwdKind),
        .fwdAbort    (fwdAbort),
        .contOk      (contOk),
        .eValid      (eValid),
        .eData       (eData),
        .eEnd        (eEnd),
        .eErr        (eErr),
        .pValid      (pValid),
        .pData       (pData),
        .pEnd        (pEnd),
        .pErr        (pErr),
        .verifyRcvd  (verifyRcvd),
        .respondRcvd (respondRcvd)
    );

endmodule

/* include/mergeRxRef.svh */
//====================================================================
// Include inside a module that imports mmsSmdPkg and mmsRxPkg.
// Preemptable CRC runs across fragments; the caller carries it along.
//====================================================================
`ifndef MERGE_RX_REF_SVH
`define MERGE_RX_REF_SVH

// Octet stream as sent on rxData or seen on a DUT output.
typedef logic [7:0] octetQ [$];

// One entry per delivered packet that is set when errored.
typedef bit markQ [$];

// Fold payload octets into a running reflected CRC-32.
function automatic logic [31:0] crcOverOctets(input logic [31:0] crc,
                                              input octetQ       data);
    logic [31:0] c;
    c = crc;
    foreach (data[i])
    begin
        // The octet enters the low end before eight shifts.
        c = c ^ {24'h0, data[i]};
        for (int n = 0; n < 8; n++)
            c = c[0] ? ((c >> 1) ^ crcPoly) : (c >> 1);
    end
    return c;
endfunction

// Check octets go low octet first; corrupt flips the first one.
function automatic octetQ fcsOctets(input logic [31:0] crc,
                                    input bit          mcrc,
                                    input bit          corrupt);
    octetQ       chk;
    logic [31:0] val;
    val = ~crc;
    if (mcrc)
        val = val ^ mcrcMask;
    if (corrupt)
        val[7:0] = ~val[7:0];
    for (int i = 0; i < 4; i++)
        chk.push_back(val[8*i +: 8]);
    return chk;
endfunction

// Whole mPacket as it appears on the wire.
function automatic octetQ buildMPacket(input int         preLen,
                                       input logic [7:0] smd,
                                       input bit         hasFrag,
                                       input logic [7:0] fragCode,
                                       input octetQ      data,
                                       input octetQ      chk);
    octetQ pkt;
    repeat (preLen)
        pkt.push_back(preambleOctet);
    pkt.push_back(smd);
    if (hasFrag)
        pkt.push_back(fragCode);
    foreach (data[i])
        pkt.push_back(data[i]);
    foreach (chk[i])
        pkt.push_back(chk[i]);
    return pkt;
endfunction

// Expected stream octets and end marker of one delivered packet.
function automatic void queueExpected(ref octetQ octs,
                                      ref markQ  marks,
                                      input octetQ data,
                                      input bit    err);
    foreach (data[i])
        octs.push_back(data[i]);
    marks.push_back(err);
endfunction

`endif

/* verification/mergeRxTb.sv */
`timescale 1ns/1ps
//====================================================================
// Expected streams are queued before each mPacket goes on the wire.
// Outputs are sampled on the falling clock edge.
//====================================================================
module mergeRxTb
    import mmsSmdPkg::*, mmsRxPkg::*;
();

    `include "mergeRxRef.svh"

    logic       clk;
    logic       reset_begin;
    logic       rxDv;
    logic [7:0] rxData;
    logic       eValid;
    logic [7:0] eData;
    logic       eEnd;
    logic       eErr;
    logic       pValid;
    logic [7:0] pData;
    logic       pEnd;
    logic       pErr;
    logic       verifyRcvd;
    logic       respondRcvd;

    int    seed = 11905;
    int    errorCount = 0;
    int    timeoutCount = 0;
    int    verifyCount = 0;
    int    respondCount = 0;
    // Expected octets and end flags per stream are consumed in order.
    octetQ expE;
    markQ  expEMarks;
    octetQ expP;
    markQ  expPMarks;

    mergeRx dut_i (
        .clk         (clk),
        .reset_begin (reset_begin),
        .rxDv        (rxDv),
        .rxData      (rxData),
        .eValid      (eValid),
        .eData       (eData),
        .eEnd        (eEnd),
        .eErr        (eErr),
        .pValid      (pValid),
        .pData       (pData),
        .pEnd        (pEnd),
        .pErr        (pErr),
        .verifyRcvd  (verifyRcvd),
        .respondRcvd (respondRcvd)
    );

    // 4 ns clock.
    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic checkValue(input string       name,
                              input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual)
        begin
            errorCount++;
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic reportExtra(input string what);
        errorCount++;
        $display("The DUT gave an %s while none was expected", what);
    endtask

    // Compare each DUT output against the head of its expected queue.
    always @(negedge clk)
    begin
        if (!reset_begin)
        begin
            if (eValid)
            begin
                if (expE.size() == 0)
                    reportExtra("express octet");
                else
                    checkValue("express data", 32'(expE.pop_front()), 32'(eData));
            end
            if (eEnd)
            begin
                if (expEMarks.size() == 0)
                    reportExtra("express end");
                else
                    checkValue("express end error", 32'(expEMarks.pop_front()), 32'(eErr));
            end
            if (pValid)
            begin
                if (expP.size() == 0)
                    reportExtra("preemptable octet");
                else
                    checkValue("preemptable data", 32'(expP.pop_front()), 32'(pData));
            end
            if (pEnd || pErr)
            begin
                if (expPMarks.size() == 0)
                    reportExtra("preemptable end");
                else
                    checkValue("preemptable end error", 32'(expPMarks.pop_front()), 32'(pErr));
            end
            if (verifyRcvd)
                verifyCount++;
            if (respondRcvd)
                respondCount++;
        end
    end

    // Payload of 4 to 20 random octets.
    function automatic octetQ randomPayload();
        octetQ d;
        int    r;
        int    len;
        r   = $random(seed);
        len = 4 + ((r & 32'h7fffffff) % 17);
        repeat (len)
        begin
            r = $random(seed);
            d.push_back(r[7:0]);
        end
        return d;
    endfunction

    // One mPacket followed by 12 idle cycles.
    task automatic sendWire(input octetQ pkt);
        foreach (pkt[i])
        begin
            @(posedge clk);
            #1;
            rxDv   = 1'b1;
            rxData = pkt[i];
        end
        @(posedge clk);
        #1;
        rxDv   = 1'b0;
        rxData = 8'h00;
        repeat (11)
            @(posedge clk);
    endtask

    task automatic sendExpress(input int preLen, input bit corrupt);
        octetQ d;
        octetQ chk;
        d   = randomPayload();
        chk = fcsOctets(crcOverOctets(crcInit, d), 1'b0, corrupt);
        queueExpected(expE, expEMarks, d, corrupt);
        sendWire(buildMPacket(preLen, smdExpress, 1'b0, 8'h00, d, chk));
    endtask

    // SMD-S plus nCont continuations with optional express traffic in between.
    task automatic sendPreempt(input int frame, input int nCont, input bit withExpress);
        octetQ       frags [4];
        octetQ       whole;
        octetQ       chk;
        logic [31:0] crc;
        logic [7:0]  smd;
        bit          last;
        for (int k = 0; k <= nCont; k++)
        begin
            frags[k] = randomPayload();
            whole    = {whole, frags[k]};
        end
        queueExpected(expP, expPMarks, whole, 1'b0);
        crc = crcInit;
        for (int k = 0; k <= nCont; k++)
        begin
            crc  = crcOverOctets(crc, frags[k]);
            last = (k == nCont);
            smd  = (k == 0) ? smdStartCodes[frame] : smdContCodes[frame];
            // mCRC on every fragment but the last.
            chk  = fcsOctets(crc, !last, 1'b0);
            sendWire(buildMPacket(2, smd, k != 0, fragCountCodes[(k + 3) % 4], frags[k], chk));
            if (withExpress && !last)
                sendExpress(1 + k, 1'b0);
        end
    endtask

    // Mode 0 sends a wrong fragment count, 1 a wrong frame count and 2 a new SMD-S.
    task automatic sendBroken(input int frame, input int mode);
        octetQ       a;
        octetQ       b;
        octetQ       chkB;
        logic [31:0] crcA;
        a    = randomPayload();
        b    = randomPayload();
        crcA = crcOverOctets(crcInit, a);
        chkB = fcsOctets(crcOverOctets(crcA, b), 1'b0, 1'b0);
        // First fragment comes out, then the abort.
        queueExpected(expP, expPMarks, a, 1'b1);
        sendWire(buildMPacket(3, smdStartCodes[frame], 1'b0, 8'h00, a,
                              fcsOctets(crcA, 1'b1, 1'b0)));
        if (mode == 0)
            sendWire(buildMPacket(3, smdContCodes[frame], 1'b1, fragCountCodes[1], b, chkB));
        else if (mode == 1)
            sendWire(buildMPacket(3, smdContCodes[(frame + 1) % 4], 1'b1, fragCountCodes[0],
                                  b, chkB));
        else
        begin
            queueExpected(expP, expPMarks, b, 1'b0);
            sendWire(buildMPacket(3, smdStartCodes[frame], 1'b0, 8'h00, b,
                                  fcsOctets(crcOverOctets(crcInit, b), 1'b0, 1'b0)));
        end
    endtask

    task automatic sendVerify(input bit respond);
        octetQ d;
        octetQ chk;
        d   = randomPayload();
        chk = fcsOctets(crcOverOctets(crcInit, d), 1'b1, 1'b0);
        sendWire(buildMPacket(1, respond ? smdRespond : smdVerify, 1'b0, 8'h00, d, chk));
    endtask

    function automatic bit streamsDrained();
        return expE.size() == 0 && expEMarks.size() == 0 &&
               expP.size() == 0 && expPMarks.size() == 0;
    endfunction

    initial
    begin
        int waitCycles;
        reset_begin = 1'b1;
        rxDv        = 1'b0;
        rxData      = 8'h00;
        repeat (10)
            @(posedge clk);
        #1;
        reset_begin = 1'b0;
        // Express with growing preamble, then one bad check.
        for (int n = 0; n < 4; n++)
            sendExpress(1 + 2 * n, 1'b0);
        sendExpress(2, 1'b1);
        sendPreempt(0, 0, 1'b0);
        for (int n = 1; n <= 3; n++)
            sendPreempt(n, n, 1'b1);
        sendBroken(1, 0);
        sendBroken(2, 1);
        sendBroken(3, 2);
        // Reassembly still works after an abort.
        sendPreempt(2, 2, 1'b1);
        sendVerify(1'b0);
        sendVerify(1'b1);
        waitCycles = 0;
        while (!streamsDrained() && waitCycles < 200)
        begin
            @(posedge clk);
            waitCycles++;
        end
        if (!streamsDrained())
        begin
            timeoutCount++;
            $display("Timed out waiting for the DUT to deliver all expected octets and ends");
        end
        // Quiet period lets late or stray outputs show up.
        repeat (20)
            @(posedge clk);
        checkValue("verifyRcvd pulses", 32'd1, 32'(verifyCount));
        checkValue("respondRcvd pulses", 32'd1, 32'(respondCount));
        $display("Mismatches: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/mmsSmdPkg.sv
hw/mmsRxPkg.sv
hw/smdDecode.sv
hw/fragmentSequencer.sv
hw/packetDeliver.sv
hw/mergeRx.sv
verification/mergeRxTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mergeRx testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mergeRxTb -f filelist.f -Mdir obj_dir -o mergeRxSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mergeRxSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0
